// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert --top-module rv_core_tb \
  -f sources.f -Mdir build/obj_dir -o rv_core_sim

./build/obj_dir/rv_core_sim | tee build/sim.log

if grep -qxF '>>> PASS' build/sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see build/sim.log"
  exit 1
fi

// ==== source/decode_read.sv ====
`timescale 1ns/10ps

module decode_read (
  input  rv_pkg::word_t instr,
  input  logic          bubble,
  stage_ctrl_if.decoder ctrl
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  // Immediates of every format. The opcode picks one.
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  // ALU operation for the register and immediate arithmetic forms.
  alu_op_e    arith_op;
  logic       arith_ok;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 gives the operation. Only SUB uses funct7, and only in the register form.
  always_comb begin
    arith_ok = 1'b1;
    case (funct3)
      3'b000:  arith_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
      3'b010:  arith_op = alu_slt;
      3'b100:  arith_op = alu_xor;
      3'b110:  arith_op = alu_or;
      3'b111:  arith_op = alu_and;
      default: begin
        arith_op = alu_add;
        arith_ok = 1'b0;
      end
    endcase
    // Any other funct7 in a register op is an unsupported encoding.
    if (opcode == op_reg && funct7 != 7'b0000000 &&
        !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
      arith_ok = 1'b0;
    end
  end

  always_comb begin
    // Defaults describe an address add of rs1 and the I immediate, with nothing enabled.
    ctrl.alu_op    = alu_add;
    ctrl.a_sel     = a_reg;
    ctrl.b_sel     = b_imm;
    ctrl.is_jump   = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.branch_ne = funct3[0];
    ctrl.reg_we    = 1'b0;
    ctrl.mem_we    = 1'b0;
    ctrl.mem_rr    = 1'b0;
    ctrl.csr_write = 1'b0;
    ctrl.rd        = instr[11:7];
    ctrl.rs1       = instr[19:15];
    ctrl.rs2       = instr[24:20];
    ctrl.imm       = imm_i;
    case (opcode)
      op_lui: begin
        ctrl.alu_op = alu_pass_b;
        ctrl.imm    = imm_u;
        ctrl.reg_we = 1'b1;
      end
      op_imm: begin
        ctrl.alu_op = arith_op;
        ctrl.reg_we = arith_ok;
      end
      op_reg: begin
        ctrl.alu_op = arith_op;
        ctrl.b_sel  = b_reg;
        ctrl.reg_we = arith_ok;
      end
      // Loads and stores exist only as word accesses.
      op_load: begin
        ctrl.mem_rr = (funct3 == 3'b010);
        ctrl.reg_we = (funct3 == 3'b010);
      end
      op_store: begin
        ctrl.imm    = imm_s;
        ctrl.mem_we = (funct3 == 3'b010);
      end
      // Branch target is PC plus the B immediate. Only BEQ and BNE exist.
      op_branch: begin
        ctrl.a_sel     = a_pc;
        ctrl.imm       = imm_b;
        ctrl.is_branch = (funct3[2:1] == 2'b00);
      end
      op_jal: begin
        ctrl.a_sel   = a_pc;
        ctrl.imm     = imm_j;
        ctrl.is_jump = 1'b1;
        ctrl.reg_we  = 1'b1;
      end
      // CSRRW to tohost passes rs1 through the ALU by adding zero.
      op_system: begin
        ctrl.imm       = '0;
        ctrl.csr_write = (funct3 == 3'b001) && (instr[31:20] == csr_tohost);
      end
      default: begin
      end
    endcase
    // The instruction behind a taken jump never takes effect.
    if (bubble) begin
      ctrl.is_jump   = 1'b0;
      ctrl.is_branch = 1'b0;
      ctrl.reg_we    = 1'b0;
      ctrl.mem_we    = 1'b0;
      ctrl.mem_rr    = 1'b0;
      ctrl.csr_write = 1'b0;
    end
  end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    reg_a,
  input  rv_pkg::word_t    reg_b,
  input  rv_pkg::word_t    imm,
  input  rv_pkg::word_t    previous,
  stage_ctrl_if.pipe       ctrl,
  input  rv_pkg::reg_idx_t prev_rd,
  input  logic             prev_reg_we,
  output logic             do_jump,
  output rv_pkg::word_t    result,
  output rv_pkg::word_t    store_data
);
  import rv_pkg::*;

  logic  fwd_a;
  logic  fwd_b;
  // Register values after forwarding.
  word_t src_a;
  word_t src_b;
  // ALU inputs after the operand selects.
  word_t op_a;
  word_t op_b;
  logic  equal;

  // The writeback instruction was too late for the register read, so its value
  // is taken here. x0 is never forwarded.
  assign fwd_a = prev_reg_we && (prev_rd != '0) && (prev_rd == ctrl.rs1);
  assign fwd_b = prev_reg_we && (prev_rd != '0) && (prev_rd == ctrl.rs2);
  assign src_a = fwd_a ? previous : reg_a;
  assign src_b = fwd_b ? previous : reg_b;

  assign op_a = (ctrl.a_sel == a_pc) ? pc : src_a;
  assign op_b = (ctrl.b_sel == b_imm) ? imm : src_b;

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    result = op_a + op_b;
      alu_sub:    result = op_a - op_b;
      alu_and:    result = op_a & op_b;
      alu_or:     result = op_a | op_b;
      alu_xor:    result = op_a ^ op_b;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

  // Branches compare the two registers. For jumps, the ALU result is the target.
  assign equal   = (src_a == src_b);
  assign do_jump = ctrl.is_jump | (ctrl.is_branch & (equal ^ ctrl.branch_ne));

  // Stores carry rs2 to memory, and a JAL carries its link value.
  assign store_data = ctrl.is_jump ? pc + word_t'(4) : src_b;

endmodule

// ==== source/program_counter.sv ====
`timescale 1ns/10ps

module program_counter #(
  parameter rv_pkg::word_t boot_addr = rv_pkg::reset_pc
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          hold,
  input  logic          do_jump,
  input  rv_pkg::word_t jump_target,
  output rv_pkg::word_t pc_decode,
  output rv_pkg::word_t next_pc
);
  import rv_pkg::*;

  // Address sent to the instruction memory in the previous cycle.
  // Its instruction is on icache_dout now.
  word_t fetch_pc;

  // A held address is presented again so the memory keeps returning the same word.
  always_comb begin
    if (do_jump) begin
      next_pc = jump_target;
    end else if (hold) begin
      next_pc = fetch_pc;
    end else begin
      next_pc = fetch_pc + word_t'(4);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_pc <= boot_addr;
    end else begin
      fetch_pc <= next_pc;
    end
  end

  assign pc_decode = fetch_pc;

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/10ps

module register_file (
  input  logic             clk,
  input  logic             hold,
  input  logic             we,
  input  rv_pkg::reg_idx_t ra1,
  input  rv_pkg::reg_idx_t ra2,
  input  rv_pkg::reg_idx_t wa,
  input  rv_pkg::word_t    wd,
  output rv_pkg::word_t    rd1,
  output rv_pkg::word_t    rd2
);
  import rv_pkg::*;

  word_t regs [32];
  // Read data after the x0 rule and the write bypass.
  word_t read1;
  word_t read2;

  // A write in the same cycle as the read is passed straight through.
  // The reading instruction then sees the new value in execute.
  assign read1 = (ra1 == '0) ? '0 : ((we && wa == ra1) ? wd : regs[ra1]);
  assign read2 = (ra2 == '0) ? '0 : ((we && wa == ra2) ? wd : regs[ra2]);

  // Writes wait out a freeze.
  // During a load pause the writeback value is not the load data yet.
  always_ff @(posedge clk) begin
    if (we && !hold && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // Read latches feeding the execute stage.
  always_ff @(posedge clk) begin
    if (!hold) begin
      rd1 <= read1;
      rd2 <= read2;
    end
  end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/10ps

module rv_core #(
  parameter rv_pkg::word_t boot_addr = rv_pkg::reset_pc
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          stall,
  output rv_pkg::word_t icache_addr,
  output logic          icache_re,
  input  rv_pkg::word_t icache_dout,
  output rv_pkg::word_t dcache_addr,
  output logic [3:0]    dcache_we,
  output logic          dcache_re,
  output rv_pkg::word_t dcache_din,
  input  rv_pkg::word_t dcache_dout,
  output rv_pkg::word_t csr
);
  import rv_pkg::*;

  // High during the first cycle after reset is released.
  logic     post_reset;
  // Writeback is starting a load and the pipeline waits for the data.
  logic     pause;
  // Freezes the PC, the pipeline registers and the register read latches.
  logic     hold;
  // A taken branch or JAL in execute. It also acts as the bubble for decode.
  logic     do_jump;

  // PC of the instruction in decode-read, execute and writeback.
  word_t    pc_d;
  word_t    pc_x;
  word_t    pc_w;

  // Register operands as latched by the register file for execute.
  word_t    reg_a;
  word_t    reg_b;

  word_t    result_x;
  word_t    store_data_x;
  word_t    result_w;
  word_t    store_data_w;
  // Value written to the register file, also forwarded to execute.
  word_t    writeback;

  // Writeback stage control.
  reg_idx_t rd_w;
  logic     reg_we_w;
  logic     mem_we_w;
  logic     mem_rr_w;
  logic     csr_write_w;
  logic     is_jump_w;

  // Decoded control, before and after the decode-read register.
  stage_ctrl_if ctrl_d ();
  stage_ctrl_if ctrl_x ();

  assign hold        = stall | pause | post_reset;
  assign icache_re   = 1'b1;
  assign dcache_re   = pause;
  // Only word accesses exist, so the low address bits are dropped.
  assign dcache_addr = {result_w[xlen-1:2], 2'b00};

  // The memories need one clock edge with a valid address before the first decode.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      post_reset <= 1'b1;
    end else begin
      post_reset <= 1'b0;
    end
  end

  // A jump seen while frozen is taken again once the freeze ends.
  // Redirecting early would bubble the target instead of the fall-through.
  program_counter #(
    .boot_addr (boot_addr)
  ) u_program_counter (
    .clk         (clk),
    .arst_n      (arst_n),
    .hold        (hold),
    .do_jump     (do_jump & ~hold),
    .jump_target (result_x),
    .pc_decode   (pc_d),
    .next_pc     (icache_addr)
  );

  register_file u_register_file (
    .clk  (clk),
    .hold (hold),
    .we   (reg_we_w),
    .ra1  (ctrl_d.rs1),
    .ra2  (ctrl_d.rs2),
    .wa   (rd_w),
    .wd   (writeback),
    .rd1  (reg_a),
    .rd2  (reg_b)
  );

  decode_read u_decode_read (
    .instr  (icache_dout),
    .bubble (do_jump),
    .ctrl   (ctrl_d)
  );

  // Decode-read to execute, enables.
  // A bubble has already cleared them inside the decoder.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_x.is_jump   <= 1'b0;
      ctrl_x.is_branch <= 1'b0;
      ctrl_x.reg_we    <= 1'b0;
      ctrl_x.mem_we    <= 1'b0;
      ctrl_x.mem_rr    <= 1'b0;
      ctrl_x.csr_write <= 1'b0;
    end else if (!hold) begin
      ctrl_x.is_jump   <= ctrl_d.is_jump;
      ctrl_x.is_branch <= ctrl_d.is_branch;
      ctrl_x.reg_we    <= ctrl_d.reg_we;
      ctrl_x.mem_we    <= ctrl_d.mem_we;
      ctrl_x.mem_rr    <= ctrl_d.mem_rr;
      ctrl_x.csr_write <= ctrl_d.csr_write;
    end
  end

  // Decode-read to execute, payload.
  always_ff @(posedge clk) begin
    if (!hold) begin
      pc_x             <= pc_d;
      ctrl_x.alu_op    <= ctrl_d.alu_op;
      ctrl_x.a_sel     <= ctrl_d.a_sel;
      ctrl_x.b_sel     <= ctrl_d.b_sel;
      ctrl_x.branch_ne <= ctrl_d.branch_ne;
      ctrl_x.rd        <= ctrl_d.rd;
      ctrl_x.rs1       <= ctrl_d.rs1;
      ctrl_x.rs2       <= ctrl_d.rs2;
      ctrl_x.imm       <= ctrl_d.imm;
    end
  end

  execute_stage u_execute_stage (
    .pc          (pc_x),
    .reg_a       (reg_a),
    .reg_b       (reg_b),
    .imm         (ctrl_x.imm),
    .previous    (writeback),
    .ctrl        (ctrl_x),
    .prev_rd     (rd_w),
    .prev_reg_we (reg_we_w),
    .do_jump     (do_jump),
    .result      (result_x),
    .store_data  (store_data_x)
  );

  // Execute to writeback, enables.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_we_w    <= 1'b0;
      mem_we_w    <= 1'b0;
      mem_rr_w    <= 1'b0;
      csr_write_w <= 1'b0;
      is_jump_w   <= 1'b0;
    end else if (!hold) begin
      reg_we_w    <= ctrl_x.reg_we;
      mem_we_w    <= ctrl_x.mem_we;
      mem_rr_w    <= ctrl_x.mem_rr;
      csr_write_w <= ctrl_x.csr_write;
      is_jump_w   <= ctrl_x.is_jump;
    end
  end

  // Execute to writeback, payload.
  always_ff @(posedge clk) begin
    if (!hold) begin
      pc_w         <= pc_x;
      rd_w         <= ctrl_x.rd;
      result_w     <= result_x;
      store_data_w <= store_data_x;
    end
  end

  writeback_stage u_writeback_stage (
    .clk          (clk),
    .arst_n       (arst_n),
    .hold         (hold),
    .mem_we       (mem_we_w),
    .mem_rr       (mem_rr_w),
    .is_jump      (is_jump_w),
    .pc           (pc_w),
    .alu_result   (result_w),
    .write_data   (store_data_w),
    .dcache_dout  (dcache_dout),
    .writeback    (writeback),
    .dcache_din   (dcache_din),
    .mem_bytes_we (dcache_we),
    .pause        (pause)
  );

  // tohost CSR. CSRRW carries rs1 through the ALU, so writeback holds its value.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csr <= '0;
    end else if (csr_write_w && !hold) begin
      csr <= writeback;
    end
  end

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

  // Data path and address width of the core.
  localparam int xlen = 32;

  // One machine word, used for data, addresses and instruction words alike.
  typedef logic [xlen-1:0] word_t;

  // Index into the 32-entry register file.
  typedef logic [4:0] reg_idx_t;

  // Major opcodes of the supported RV32I subset.
  // The values are the low seven bits of the instruction word.
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } opcode_e;

  // Operations of the execute stage ALU.
  // alu_pass_b forwards the second operand unchanged, which LUI relies on.
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  // First ALU operand: register rs1 or the PC of the instruction.
  typedef enum logic {
    a_reg,
    a_pc
  } a_sel_e;

  // Second ALU operand: register rs2 or the decoded immediate.
  typedef enum logic {
    b_reg,
    b_imm
  } b_sel_e;

  // CSR number of the tohost register seen by the testbench.
  localparam logic [11:0] csr_tohost = 12'h51E;

  // Default address of the first fetch after reset.
  localparam word_t reset_pc = 32'h0000_0000;

endpackage

// ==== source/stage_ctrl_if.sv ====
`timescale 1ns/10ps

interface stage_ctrl_if;
  import rv_pkg::*;

  // ALU operation and operand selects.
  alu_op_e  alu_op;
  a_sel_e   a_sel;
  b_sel_e   b_sel;
  // Control flow. branch_ne flips the sense of the equality test.
  logic     is_jump;
  logic     is_branch;
  logic     branch_ne;
  // Enables for the register file, the data memory and the tohost CSR.
  logic     reg_we;
  logic     mem_we;
  logic     mem_rr;
  logic     csr_write;
  // Register indices and the sign-extended immediate.
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm;

  // The decoder produces every field.
  modport decoder (
    output alu_op, a_sel, b_sel, is_jump, is_branch, branch_ne,
           reg_we, mem_we, mem_rr, csr_write, rd, rs1, rs2, imm
  );

  // A pipeline stage only consumes them.
  modport pipe (
    input alu_op, a_sel, b_sel, is_jump, is_branch, branch_ne,
          reg_we, mem_we, mem_rr, csr_write, rd, rs1, rs2, imm
  );

endinterface

// ==== source/writeback_stage.sv ====
`timescale 1ns/10ps

module writeback_stage (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          hold,
  input  logic          mem_we,
  input  logic          mem_rr,
  input  logic          is_jump,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t alu_result,
  input  rv_pkg::word_t write_data,
  input  rv_pkg::word_t dcache_dout,
  output rv_pkg::word_t writeback,
  output rv_pkg::word_t dcache_din,
  output logic [3:0]    mem_bytes_we,
  output logic          pause
);
  import rv_pkg::*;

  // Set once the load address has been presented for a cycle.
  // From then on dcache_dout holds the loaded word.
  logic load_done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      load_done <= 1'b0;
    end else if (!hold) begin
      load_done <= 1'b0;
    end else if (mem_rr) begin
      load_done <= 1'b1;
    end
  end

  // One pause cycle per load, even when an external stall follows.
  assign pause = mem_rr & ~load_done;

  // All four bytes for a word store, written only in the cycle the stage advances.
  assign mem_bytes_we = (mem_we && !hold) ? 4'b1111 : 4'b0000;
  assign dcache_din   = write_data;

  always_comb begin
    if (mem_rr) begin
      writeback = dcache_dout;
    end else if (is_jump) begin
      writeback = pc + word_t'(4);
    end else begin
      writeback = alu_result;
    end
  end

endmodule

// ==== sources.f ====
source/rv_pkg.sv
source/stage_ctrl_if.sv
source/program_counter.sv
source/register_file.sv
source/decode_read.sv
source/execute_stage.sv
source/writeback_stage.sv
source/rv_core.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_props.sv ====
`timescale 1ns/10ps

module rv_core_props (
  input logic       clk,
  input logic       arst_n,
  input logic       pause,
  input logic [3:0] dcache_we,
  input logic       dcache_re
);

  // Nothing may be written to the data memory while the core is in reset.
  reset_quiet: assert property (@(posedge clk) !arst_n |-> dcache_we == 4'b0000)
    else $error("dcache_we was active during reset");

  // A load pauses the pipeline for one cycle only.
  // The data is on dcache_dout by the next cycle.
  single_pause: assert property (@(posedge clk) disable iff (!arst_n) pause |=> !pause)
    else $error("pause stayed high for two cycles in a row");

  // The data memory port carries a read or a write, never both
  no_rw_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    !(dcache_we != 4'b0000 && dcache_re))
    else $error("dcache_we and dcache_re were active in the same cycle");

endmodule

// Attach the checks to every instance of the core.
bind rv_core rv_core_props u_rv_core_props (
  .clk       (clk),
  .arst_n    (arst_n),
  .pause     (pause),
  .dcache_we (dcache_we),
  .dcache_re (dcache_re)
);

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb;
  import rv_pkg::*;

  // Clock, reset and the random stall source.
  logic   clk = 1'b0;
  logic   arst_n = 1'b0;
  logic   stall = 1'b0;
  integer seed = 27336;

  // Memory side of the DUT.
  word_t       icache_addr;
  logic        icache_re;
  word_t       icache_dout = '0;
  word_t       dcache_addr;
  logic [3:0]  dcache_we;
  logic        dcache_re;
  word_t       dcache_din;
  word_t       dcache_dout = '0;
  word_t       csr;

  // Instruction and data memories, 256 words each.
  word_t imem [256];
  word_t dmem [256];
  int    asm_at = 0;

  // Stores predicted by the reference, consumed in order by the comparing process.
  word_t exp_addr [$];
  word_t exp_data [$];
  // Load addresses, one for each load pause of the core.
  word_t exp_load [$];
  word_t exp_tohost;
  int    stores_seen = 0;

  always #10 clk = ~clk;

  rv_core #(
    .boot_addr (reset_pc)
  ) u_rv_core (
    .clk         (clk),
    .arst_n      (arst_n),
    .stall       (stall),
    .icache_addr (icache_addr),
    .icache_re   (icache_re),
    .icache_dout (icache_dout),
    .dcache_addr (dcache_addr),
    .dcache_we   (dcache_we),
    .dcache_re   (dcache_re),
    .dcache_din  (dcache_din),
    .dcache_dout (dcache_dout),
    .csr         (csr)
  );

  // Both memories register the address, so data shows up one cycle later.
  // A store in the same edge does not affect the word read out.
  always @(posedge clk) begin
    icache_dout <= imem[icache_addr[9:2]];
    dcache_dout <= dmem[dcache_addr[9:2]];
    if (dcache_we == 4'b1111) begin
      dmem[dcache_addr[9:2]] = dcache_din;
    end
  end

  // Roughly one cycle in four is stalled once reset is over.
  always @(posedge clk) begin
    if (arst_n) begin
      stall <= (($random(seed) & 3) == 0);
    end else begin
      stall <= 1'b0;
    end
  end

  // Initial data memory contents, a mix of every address bit.
  function automatic word_t fill_word(int idx);
    return (word_t'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  // Instruction encoders, one per RV32I format.
  function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                   reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t i_type(opcode_e op, logic [2:0] f3, reg_idx_t rd,
                                   reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic word_t b_type(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                   logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t u_type(opcode_e op, reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  task automatic emit(input word_t word);
    imem[asm_at] = word;
    asm_at = asm_at + 1;
  endtask

  // The test program. x20 is the base of the result area at 0x100.
  task automatic load_program();
    emit(i_type(op_imm, 3'b000, 5'd20, 5'd0, 12'h100));
    // Each result feeds the next one, so most operands come from forwarding.
    emit(u_type(op_lui, 5'd1, 20'h12345));
    emit(i_type(op_imm, 3'b000, 5'd2, 5'd1, 12'h678));
    emit(i_type(op_imm, 3'b000, 5'd3, 5'd0, 12'hFFB));
    emit(r_type(7'h00, 3'b000, 5'd4, 5'd2, 5'd3));
    emit(r_type(7'h20, 3'b000, 5'd5, 5'd4, 5'd1));
    emit(r_type(7'h00, 3'b111, 5'd6, 5'd2, 5'd3));
    emit(r_type(7'h00, 3'b110, 5'd7, 5'd5, 5'd6));
    emit(r_type(7'h00, 3'b100, 5'd8, 5'd7, 5'd2));
    emit(r_type(7'h00, 3'b010, 5'd9, 5'd3, 5'd0));
    emit(i_type(op_imm, 3'b010, 5'd10, 5'd2, 12'h001));
    emit(s_type(5'd4, 5'd20, 12'd0));
    emit(s_type(5'd5, 5'd20, 12'd4));
    emit(s_type(5'd8, 5'd20, 12'd8));
    emit(s_type(5'd9, 5'd20, 12'd12));
    emit(i_type(op_imm, 3'b111, 5'd11, 5'd2, 12'h0F0));
    emit(i_type(op_imm, 3'b110, 5'd12, 5'd11, 12'hF00));
    emit(i_type(op_imm, 3'b100, 5'd13, 5'd12, 12'h555));
    emit(s_type(5'd13, 5'd20, 12'd16));
    emit(s_type(5'd10, 5'd20, 12'd20));
    // BEQ falls through, BNE skips the ADDI that would overwrite x9.
    emit(b_type(3'b000, 5'd9, 5'd10, 13'd8));
    emit(b_type(3'b001, 5'd9, 5'd10, 13'd8));
    emit(i_type(op_imm, 3'b000, 5'd9, 5'd0, 12'h7FF));
    emit(s_type(5'd9, 5'd20, 12'd24));
    emit(b_type(3'b000, 5'd9, 5'd9, 13'd8));
    emit(s_type(5'd1, 5'd20, 12'd28));
    // A BNE of equal registers falls through to the JAL.
    emit(b_type(3'b001, 5'd9, 5'd9, 13'd8));
    // JAL links into x15 and jumps over two instructions.
    emit(j_type(5'd15, 21'd12));
    emit(i_type(op_imm, 3'b000, 5'd8, 5'd0, 12'h063));
    emit(s_type(5'd8, 5'd20, 12'd32));
    emit(s_type(5'd15, 5'd20, 12'd36));
    emit(s_type(5'd8, 5'd20, 12'd40));
    // Loads used by the very next instruction.
    emit(i_type(op_load, 3'b010, 5'd16, 5'd20, 12'd8));
    emit(r_type(7'h00, 3'b000, 5'd17, 5'd16, 5'd4));
    emit(s_type(5'd17, 5'd20, 12'd44));
    emit(i_type(op_load, 3'b010, 5'd18, 5'd0, 12'd128));
    emit(s_type(5'd18, 5'd20, 12'd48));
    emit(i_type(op_system, 3'b001, 5'd0, 5'd17, csr_tohost));
    emit(j_type(5'd0, 21'd0));
  endtask

  // Integer operation selected by funct3, as the ISA defines it.
  function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t x, word_t y);
    case (f3)
      3'b000:  return sub ? x - y : x + y;
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b110:  return x | y;
      3'b111:  return x & y;
      default: return '0;
    endcase
  endfunction

  // Instruction level model of the program. Fills the store and load queues
  // and returns the value that the CSRRW sends to tohost.
  function automatic word_t run_reference();
    word_t       regs [32];
    word_t       mem [256];
    word_t       pc;
    word_t       ins;
    word_t       a;
    word_t       b;
    word_t       addr;
    word_t       next;
    word_t       tohost;
    logic [2:0]  f3;
    logic [12:0] off_b;
    logic [20:0] off_j;
    reg_idx_t    rd;
    int          steps;
    logic        done;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i);
    end
    pc = reset_pc;
    tohost = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 2000) begin
      ins = imem[pc[9:2]];
      f3 = ins[14:12];
      rd = ins[11:7];
      a = regs[ins[19:15]];
      b = regs[ins[24:20]];
      next = pc + 32'd4;
      case (opcode_e'(ins[6:0]))
        op_lui:  regs[rd] = {ins[31:12], 12'h000};
        op_imm:  regs[rd] = alu_ref(f3, 1'b0, a, {{20{ins[31]}}, ins[31:20]});
        op_reg:  regs[rd] = alu_ref(f3, ins[30], a, b);
        op_load: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          addr[1:0] = 2'b00;
          regs[rd] = mem[addr[9:2]];
          exp_load.push_back(addr);
        end
        op_store: begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          addr[1:0] = 2'b00;
          mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        op_branch: begin
          off_b = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          // funct3 bit 0 turns BEQ into BNE.
          if ((a == b) != f3[0]) begin
            next = pc + {{19{off_b[12]}}, off_b};
          end
        end
        op_jal: begin
          off_j = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
          regs[rd] = pc + 32'd4;
          next = pc + {{11{off_j[20]}}, off_j};
        end
        op_system: begin
          if (f3 == 3'b001 && ins[31:20] == csr_tohost) begin
            tohost = a;
            done = 1'b1;
          end
        end
        default: begin
        end
      endcase
      regs[0] = '0;
      pc = next;
      steps = steps + 1;
    end
    return tohost;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h",
                          name, actual, expected));
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s: got 0x%01h, expected 0x%01h",
                          name, actual, expected));
    end
  endtask

  task automatic check_strobe(input string name, input logic [3:0] actual,
                              input logic [3:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s: got 0x%01h, expected 0x%01h",
                          name, actual, expected));
    end
  endtask

  // Matches one store of the DUT with the oldest store the reference predicted.
  task automatic check_store(input word_t address, input word_t data);
    word_t want_addr;
    word_t want_data;
    if (exp_addr.size() == 0) begin
      abort_run($sformatf("The core stored to 0x%08h after the last expected store.",
                          address));
    end else begin
      want_addr = exp_addr.pop_front();
      want_data = exp_data.pop_front();
      check_word("dcache_addr", address, want_addr);
      check_word("dcache_din", data, want_data);
    end
  endtask

  // Matches one load pause of the DUT with the oldest load the reference predicted.
  task automatic check_load(input word_t address);
    word_t want_addr;
    if (exp_load.size() == 0) begin
      abort_run($sformatf("The core loaded from 0x%08h after the last expected load.",
                          address));
    end else begin
      want_addr = exp_load.pop_front();
      check_word("dcache_addr", address, want_addr);
    end
  endtask

  // Stores and loads are sampled mid-cycle, where the strobes are settled.
  // The tohost write comes last, so csr must still be zero at every store.
  always @(negedge clk) begin
    if (arst_n) begin
      check_bit("icache_re", icache_re, 1'b1);
      if (dcache_re) begin
        check_load(dcache_addr);
      end
      if (dcache_we != 4'b0000) begin
        check_strobe("dcache_we", dcache_we, 4'b1111);
        check_word("csr", csr, '0);
        check_store(dcache_addr, dcache_din);
        stores_seen = stores_seen + 1;
      end
    end
  end

  initial begin
    int cycles;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = fill_word(i);
    end
    load_program();
    exp_tohost = run_reference();
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_word("csr", csr, '0);
    check_strobe("dcache_we", dcache_we, 4'b0000);
    check_bit("dcache_re", dcache_re, 1'b0);
    // The program ends with the tohost write followed by a jump to itself.
    cycles = 0;
    while (csr == '0 && cycles < 4000) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (csr == '0) begin
      abort_run("Timed out waiting for the program to write tohost.");
    end
    check_word("csr", csr, exp_tohost);
    // A few more cycles show that nothing else is stored after tohost.
    repeat (20) @(negedge clk);
    if (exp_addr.size() != 0) begin
      abort_run($sformatf("Only %0d stores were seen, %0d more were expected.",
                          stores_seen, exp_addr.size()));
    end else if (exp_load.size() != 0) begin
      abort_run($sformatf("%0d expected loads never reached the data memory.",
                          exp_load.size()));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule
